/* rtl/snn_pkg.sv */
`default_nettype none

package snn_pkg;

    localparam int WORD_W        = 32;                   // Register word width
    localparam int NUM_REGS      = 16;                   // Words per bank
    localparam int REG_IDX_W     = 4;                    // Register index width
    localparam int VEC_W         = NUM_REGS * WORD_W;    // Full vector width
    localparam int VAL_W         = 4;                    // One weight or one current
    localparam int VALS_PER_WORD = WORD_W / VAL_W;       // Eight values per word
    localparam int NUM_NEURONS   = VEC_W / VAL_W;        // 128 neurons

    typedef enum logic [1:0] {
        UNIT_WEIGHT  = 2'd0,
        UNIT_SPIKE   = 2'd1,
        UNIT_CURRENT = 2'd2,
        UNIT_ACCUM   = 2'd3
    } unit_t;

    typedef logic [2:0] funct_t;

    localparam funct_t F_STORE1    = 3'd0;   // Store word rd
    localparam funct_t F_STORE4    = 3'd1;   // Store words rd..rd+3, wrapping
    localparam funct_t F_STORE16   = 3'd2;   // Store whole bank from register 0
    localparam funct_t F_LOAD1     = 3'd3;   // Load one lane
    localparam funct_t F_LOAD4     = 3'd4;   // Load four lanes
    localparam funct_t F_LOAD16    = 3'd5;   // Load all sixteen lanes
    localparam funct_t F_STORE_NIB = 3'd6;   // Current bank only, low nibble of rd
    localparam funct_t F_ACCUM     = 3'd7;   // Accumulator only

    typedef logic [VALS_PER_WORD-1:0][VAL_W-1:0] weight_word_t;   // Eight 4-bit weights
    typedef logic [WORD_W-1:0]                   spike_word_t;    // One bit per neuron
    typedef logic [VEC_W-1:0]                    vec_t;

    // Number of consecutive words touched by a word store or load
    function automatic int word_span(funct_t f);
        case (f)
            F_STORE1, F_LOAD1:   return 1;
            F_STORE4, F_LOAD4:   return 4;
            F_STORE16, F_LOAD16: return NUM_REGS;
            default:             return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* rtl/command_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module command_decode (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  cmd_valid,
    input  wire snn_pkg::unit_t  cmd_unit,
    input  wire snn_pkg::funct_t cmd_funct,
    output logic                 w_en,
    output logic                 s_en,
    output logic                 c_en,
    output logic                 acc_go,
    output logic                 cmd_err
);

    logic legal;   // Funct code is supported by the addressed unit

    always_comb begin
        case (cmd_unit)
            snn_pkg::UNIT_WEIGHT, snn_pkg::UNIT_SPIKE: begin
                legal = cmd_funct inside {snn_pkg::F_STORE1, snn_pkg::F_STORE4,
                                          snn_pkg::F_STORE16, snn_pkg::F_LOAD1,
                                          snn_pkg::F_LOAD4, snn_pkg::F_LOAD16};
            end
            snn_pkg::UNIT_CURRENT: begin
                legal = cmd_funct inside {snn_pkg::F_STORE1, snn_pkg::F_STORE4,
                                          snn_pkg::F_STORE16, snn_pkg::F_STORE_NIB};
            end
            default: begin
                legal = (cmd_funct == snn_pkg::F_ACCUM);   // Accumulator takes one code
            end
        endcase
    end

    // Exactly one enable per legal command
    assign w_en   = cmd_valid && legal && (cmd_unit == snn_pkg::UNIT_WEIGHT);
    assign s_en   = cmd_valid && legal && (cmd_unit == snn_pkg::UNIT_SPIKE);
    assign c_en   = cmd_valid && legal && (cmd_unit == snn_pkg::UNIT_CURRENT);
    assign acc_go = cmd_valid && legal && (cmd_unit == snn_pkg::UNIT_ACCUM);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_err <= 1'b0;
        end else begin
            cmd_err <= cmd_valid && !legal;   // One-cycle pulse per rejected command
        end
    end

endmodule

`default_nettype wire

/* rtl/vector_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_reg_bank #(
    parameter type word_t = snn_pkg::weight_word_t
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              en,
    input  wire snn_pkg::funct_t             funct,
    input  wire [snn_pkg::REG_IDX_W-1:0]     rd,
    input  wire snn_pkg::vec_t               data,
    output snn_pkg::vec_t                    vec
);

    word_t                         regs [snn_pkg::NUM_REGS];   // Register file
    logic [snn_pkg::REG_IDX_W-1:0] idx  [snn_pkg::NUM_REGS];   // Register for word k
    logic [snn_pkg::REG_IDX_W-1:0] base;
    logic                          is_load;
    int                            span;                       // Words touched

    always_comb begin
        span    = snn_pkg::word_span(funct);
        is_load = funct inside {snn_pkg::F_LOAD1, snn_pkg::F_LOAD4, snn_pkg::F_LOAD16};
        // Full-bank store always lands at register 0, every other access starts at rd
        base    = (funct == snn_pkg::F_STORE16) ? '0 : rd;
        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
            idx[k] = base + k[snn_pkg::REG_IDX_W-1:0];   // Wraps modulo 16
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                regs[k] <= '0;
            end
            vec <= '0;
        end else if (en) begin
            for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                if (k < span) begin
                    if (is_load) begin
                        // Lane k gets register rd+k, other lanes hold
                        vec[k*snn_pkg::WORD_W +: snn_pkg::WORD_W] <= regs[idx[k]];
                    end else begin
                        regs[idx[k]] <= data[k*snn_pkg::WORD_W +: snn_pkg::WORD_W];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/current_reg_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module current_reg_bank (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              en,
    input  wire snn_pkg::funct_t             funct,
    input  wire [snn_pkg::REG_IDX_W-1:0]     rd,
    input  wire snn_pkg::vec_t               data,
    input  wire                              acc_we,
    input  wire snn_pkg::vec_t               acc_sum,
    output snn_pkg::vec_t                    cur_vec
);

    logic [snn_pkg::WORD_W-1:0]    cur_regs [snn_pkg::NUM_REGS];   // Eight currents per word
    logic [snn_pkg::REG_IDX_W-1:0] idx      [snn_pkg::NUM_REGS];
    logic [snn_pkg::REG_IDX_W-1:0] base;
    int                            span;

    always_comb begin
        span = snn_pkg::word_span(funct);
        base = (funct == snn_pkg::F_STORE16) ? '0 : rd;
        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
            idx[k] = base + k[snn_pkg::REG_IDX_W-1:0];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                cur_regs[k] <= '0;
            end
        end else if (acc_we) begin
            // Accumulator write-back replaces the whole bank
            for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                cur_regs[k] <= acc_sum[k*snn_pkg::WORD_W +: snn_pkg::WORD_W];
            end
        end else if (en) begin
            if (funct == snn_pkg::F_STORE_NIB) begin
                cur_regs[rd][snn_pkg::VAL_W-1:0] <= data[snn_pkg::VAL_W-1:0];   // Neuron 0 of rd
            end else begin
                for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                    if (k < span) begin
                        cur_regs[idx[k]] <= data[k*snn_pkg::WORD_W +: snn_pkg::WORD_W];
                    end
                end
            end
        end
    end

    // Word i sits at bits 32i upward
    always_comb begin
        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
            cur_vec[k*snn_pkg::WORD_W +: snn_pkg::WORD_W] = cur_regs[k];
        end
    end

endmodule

`default_nettype wire

/* rtl/synapse_accumulator.sv */
`timescale 1ns/1ps
`default_nettype none

module synapse_accumulator (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 acc_go,
    input  wire snn_pkg::vec_t  w_vec,
    input  wire snn_pkg::vec_t  s_vec,
    input  wire snn_pkg::vec_t  cur_vec,
    output snn_pkg::vec_t       acc_sum,
    output logic                acc_we,
    output snn_pkg::vec_t       acc_out,
    output logic                acc_valid
);

    logic [snn_pkg::VAL_W-1:0] gated_w;   // Weight after spike gating

    // One 4-bit adder per neuron, carry out dropped
    always_comb begin
        gated_w = '0;
        for (int i = 0; i < snn_pkg::NUM_NEURONS; i++) begin
            gated_w = s_vec[i] ? w_vec[i*snn_pkg::VAL_W +: snn_pkg::VAL_W] : '0;
            acc_sum[i*snn_pkg::VAL_W +: snn_pkg::VAL_W] =
                cur_vec[i*snn_pkg::VAL_W +: snn_pkg::VAL_W] + gated_w;
        end
    end

    assign acc_we = acc_go;   // Write-back lands on the same edge

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_out   <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= acc_go;
            if (acc_go) begin
                acc_out <= acc_sum;   // Last result stays until the next accumulate
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/snn_core.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_core (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              cmd_valid,
    input  wire snn_pkg::unit_t              cmd_unit,
    input  wire snn_pkg::funct_t             cmd_funct,
    input  wire [snn_pkg::REG_IDX_W-1:0]     cmd_rd,
    input  wire snn_pkg::vec_t               cmd_data,
    output snn_pkg::vec_t                    w_vec,
    output snn_pkg::vec_t                    s_vec,
    output snn_pkg::vec_t                    cur_vec,
    output snn_pkg::vec_t                    acc_out,
    output logic                             acc_valid,
    output logic                             cmd_err
);

    logic          w_en;
    logic          s_en;
    logic          c_en;
    logic          acc_go;
    logic          acc_we;    // Accumulator write-back strobe
    snn_pkg::vec_t acc_sum;   // Combinational accumulator result

    command_decode u_decode (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_unit  (cmd_unit),
        .cmd_funct (cmd_funct),
        .w_en      (w_en),
        .s_en      (s_en),
        .c_en      (c_en),
        .acc_go    (acc_go),
        .cmd_err   (cmd_err)
    );

    vector_reg_bank #(
        .word_t (snn_pkg::weight_word_t)
    ) u_weight_bank (
        .clk   (clk),
        .reset (reset),
        .en    (w_en),
        .funct (cmd_funct),
        .rd    (cmd_rd),
        .data  (cmd_data),
        .vec   (w_vec)
    );

    vector_reg_bank #(
        .word_t (snn_pkg::spike_word_t)
    ) u_spike_bank (
        .clk   (clk),
        .reset (reset),
        .en    (s_en),
        .funct (cmd_funct),
        .rd    (cmd_rd),
        .data  (cmd_data),
        .vec   (s_vec)
    );

    current_reg_bank u_current_bank (
        .clk     (clk),
        .reset   (reset),
        .en      (c_en),
        .funct   (cmd_funct),
        .rd      (cmd_rd),
        .data    (cmd_data),
        .acc_we  (acc_we),
        .acc_sum (acc_sum),
        .cur_vec (cur_vec)
    );

    synapse_accumulator u_accum (
        .clk       (clk),
        .reset     (reset),
        .acc_go    (acc_go),
        .w_vec     (w_vec),
        .s_vec     (s_vec),
        .cur_vec   (cur_vec),
        .acc_sum   (acc_sum),
        .acc_we    (acc_we),
        .acc_out   (acc_out),
        .acc_valid (acc_valid)
    );

endmodule

`default_nettype wire

/* testbench/snn_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_core_chk (
    input wire                          clk,
    input wire                          reset,
    input wire                          cmd_valid,
    input wire snn_pkg::unit_t          cmd_unit,
    input wire snn_pkg::funct_t         cmd_funct,
    input wire [snn_pkg::REG_IDX_W-1:0] cmd_rd,
    input wire snn_pkg::vec_t           cmd_data,
    input wire snn_pkg::vec_t           w_vec,
    input wire snn_pkg::vec_t           s_vec,
    input wire snn_pkg::vec_t           cur_vec,
    input wire snn_pkg::vec_t           acc_out,
    input wire                          acc_valid,
    input wire                          cmd_err
);

    logic [snn_pkg::WORD_W-1:0]    m_w  [snn_pkg::NUM_REGS];   // Weight registers
    logic [snn_pkg::WORD_W-1:0]    m_s  [snn_pkg::NUM_REGS];   // Spike registers
    logic [snn_pkg::WORD_W-1:0]    m_c  [snn_pkg::NUM_REGS];   // Current registers
    logic [snn_pkg::REG_IDX_W-1:0] slot [snn_pkg::NUM_REGS];   // Register for word k
    logic [snn_pkg::REG_IDX_W-1:0] start;
    snn_pkg::vec_t                 m_wv;                       // Expected load vectors
    snn_pkg::vec_t                 m_sv;
    snn_pkg::vec_t                 m_cv;
    snn_pkg::vec_t                 m_sum;                      // Expected accumulate result
    snn_pkg::vec_t                 m_acc;
    logic                          m_acc_valid;
    logic                          m_err;
    logic                          legal;
    logic                          is_load;
    int                            n_words;
    int                            err_count = 0;              // Read by the testbench

    function automatic logic unit_accepts(snn_pkg::unit_t u, snn_pkg::funct_t f);
        logic store_code;
        logic load_code;
        store_code = (f == snn_pkg::F_STORE1) || (f == snn_pkg::F_STORE4)
                     || (f == snn_pkg::F_STORE16);
        load_code  = (f == snn_pkg::F_LOAD1) || (f == snn_pkg::F_LOAD4)
                     || (f == snn_pkg::F_LOAD16);
        case (u)
            snn_pkg::UNIT_WEIGHT, snn_pkg::UNIT_SPIKE: return store_code || load_code;
            snn_pkg::UNIT_CURRENT: return store_code || (f == snn_pkg::F_STORE_NIB);
            default: return f == snn_pkg::F_ACCUM;
        endcase
    endfunction

    task automatic count_failure(input string what);
        err_count++;
        $error("Fail %0t: %s", $time, what);
    endtask

    always_comb begin
        case (cmd_funct)
            snn_pkg::F_STORE1, snn_pkg::F_LOAD1:   n_words = 1;
            snn_pkg::F_STORE4, snn_pkg::F_LOAD4:   n_words = 4;
            snn_pkg::F_STORE16, snn_pkg::F_LOAD16: n_words = 16;
            default:                               n_words = 0;
        endcase
        is_load = (cmd_funct == snn_pkg::F_LOAD1) || (cmd_funct == snn_pkg::F_LOAD4)
                  || (cmd_funct == snn_pkg::F_LOAD16);
        legal   = unit_accepts(cmd_unit, cmd_funct);
        start   = (cmd_funct == snn_pkg::F_STORE16) ? '0 : cmd_rd;
        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
            slot[k] = start + k[snn_pkg::REG_IDX_W-1:0];   // Wraps at 16
        end
    end

    always_comb begin
        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
            m_cv[k*32 +: 32] = m_c[k];
        end
    end

    // Spike bit i gates weight nibble i onto current nibble i
    always_comb begin
        for (int i = 0; i < 128; i++) begin
            m_sum[i*4 +: 4] = m_cv[i*4 +: 4] + (m_sv[i] ? m_wv[i*4 +: 4] : 4'd0);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                m_w[k] <= '0;
                m_s[k] <= '0;
                m_c[k] <= '0;
            end
            m_wv        <= '0;
            m_sv        <= '0;
            m_acc       <= '0;
            m_acc_valid <= 1'b0;
            m_err       <= 1'b0;
        end else begin
            m_acc_valid <= 1'b0;
            m_err       <= cmd_valid && !legal;
            if (cmd_valid && legal) begin
                case (cmd_unit)
                    snn_pkg::UNIT_WEIGHT: begin
                        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                            if (k < n_words && is_load) m_wv[k*32 +: 32] <= m_w[slot[k]];
                            if (k < n_words && !is_load) m_w[slot[k]] <= cmd_data[k*32 +: 32];
                        end
                    end
                    snn_pkg::UNIT_SPIKE: begin
                        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                            if (k < n_words && is_load) m_sv[k*32 +: 32] <= m_s[slot[k]];
                            if (k < n_words && !is_load) m_s[slot[k]] <= cmd_data[k*32 +: 32];
                        end
                    end
                    snn_pkg::UNIT_CURRENT: begin
                        if (cmd_funct == snn_pkg::F_STORE_NIB) begin
                            m_c[cmd_rd][3:0] <= cmd_data[3:0];
                        end else begin
                            for (int k = 0; k < n_words; k++) begin
                                m_c[slot[k]] <= cmd_data[k*32 +: 32];
                            end
                        end
                    end
                    default: begin
                        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
                            m_c[k] <= m_sum[k*32 +: 32];   // Write-back
                        end
                        m_acc       <= m_sum;
                        m_acc_valid <= 1'b1;
                    end
                endcase
            end
        end
    end

    a_reset_clear: assert property (@(posedge clk) $fell(reset) |->
        (w_vec == '0 && s_vec == '0 && cur_vec == '0 && acc_out == '0
         && !acc_valid && !cmd_err))
        else count_failure("outputs not clear after reset");

    a_w_vec: assert property (@(posedge clk) disable iff (reset) cmd_valid |=> w_vec == m_wv)
        else count_failure("w_vec differs from model");

    a_s_vec: assert property (@(posedge clk) disable iff (reset) cmd_valid |=> s_vec == m_sv)
        else count_failure("s_vec differs from model");

    a_cur_vec: assert property (@(posedge clk) disable iff (reset) cmd_valid |=> cur_vec == m_cv)
        else count_failure("cur_vec differs from model");

    a_acc_out: assert property (@(posedge clk) disable iff (reset) cmd_valid |=> acc_out == m_acc)
        else count_failure("acc_out differs from model");

    a_acc_valid: assert property (@(posedge clk) disable iff (reset) acc_valid == m_acc_valid)
        else count_failure("acc_valid pulse wrong");

    a_cmd_err: assert property (@(posedge clk) disable iff (reset) cmd_err == m_err)
        else count_failure("cmd_err pulse wrong");

endmodule

bind snn_core snn_core_chk u_chk (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd_unit  (cmd_unit),
    .cmd_funct (cmd_funct),
    .cmd_rd    (cmd_rd),
    .cmd_data  (cmd_data),
    .w_vec     (w_vec),
    .s_vec     (s_vec),
    .cur_vec   (cur_vec),
    .acc_out   (acc_out),
    .acc_valid (acc_valid),
    .cmd_err   (cmd_err)
);

`default_nettype wire

/* testbench/snn_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module snn_core_tb;

    localparam int RESET_CYCLES   = 3;
    localparam int NUM_CMDS       = 23;   // Commands in the script below
    localparam int IDLE_CYCLES    = 14;   // Idle cycles in the script below
    localparam int TIMEOUT_CYCLES = 2 * (NUM_CMDS + IDLE_CYCLES) + RESET_CYCLES;

    logic                          clk;
    logic                          reset;
    logic                          cmd_valid;
    snn_pkg::unit_t                cmd_unit;
    snn_pkg::funct_t               cmd_funct;
    logic [snn_pkg::REG_IDX_W-1:0] cmd_rd;
    snn_pkg::vec_t                 cmd_data;
    snn_pkg::vec_t                 w_vec;
    snn_pkg::vec_t                 s_vec;
    snn_pkg::vec_t                 cur_vec;
    snn_pkg::vec_t                 acc_out;
    logic                          acc_valid;
    logic                          cmd_err;
    int                            seed = 32'h7213_7833;
    int                            cycle_count = 0;

    snn_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .cmd_valid (cmd_valid),
        .cmd_unit  (cmd_unit),
        .cmd_funct (cmd_funct),
        .cmd_rd    (cmd_rd),
        .cmd_data  (cmd_data),
        .w_vec     (w_vec),
        .s_vec     (s_vec),
        .cur_vec   (cur_vec),
        .acc_out   (acc_out),
        .acc_valid (acc_valid),
        .cmd_err   (cmd_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic snn_pkg::vec_t rand_vec();
        snn_pkg::vec_t v;
        for (int k = 0; k < snn_pkg::NUM_REGS; k++) begin
            v[k*32 +: 32] = $random(seed);
        end
        return v;
    endfunction

    // Drive one command for one cycle, starting at a falling edge
    task automatic send(input snn_pkg::unit_t unit, input snn_pkg::funct_t funct,
                        input logic [snn_pkg::REG_IDX_W-1:0] rd, input snn_pkg::vec_t data);
        cmd_valid = 1'b1;
        cmd_unit  = unit;
        cmd_funct = funct;
        cmd_rd    = rd;
        cmd_data  = data;
        @(negedge clk);
    endtask

    task automatic idle(input int cycles);
        cmd_valid = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // Word store then load sequence shared by both vector banks
    task automatic exercise_vector_bank(input snn_pkg::unit_t unit);
        send(unit, snn_pkg::F_STORE16, 4'd9, rand_vec());   // rd ignored
        send(unit, snn_pkg::F_STORE1, 4'd3, rand_vec());
        send(unit, snn_pkg::F_STORE4, 4'd14, rand_vec());   // Wraps to 0 and 1
        send(unit, snn_pkg::F_LOAD16, 4'd7, '0);            // Fills every lane
        send(unit, snn_pkg::F_LOAD1, 4'd2, '0);             // Lanes 1 to 15 hold
        send(unit, snn_pkg::F_LOAD4, 4'd14, '0);            // Lanes 4 to 15 hold
        idle(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation failed");
            $fatal(1, "Timeout after %0d cycles, the command script did not finish",
                   cycle_count);
        end
    end

    always @(negedge clk) begin
        if (u_dut.u_chk.err_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "Checker assertion failed at %0t", $time);
        end
    end

    initial begin
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_unit  = snn_pkg::UNIT_WEIGHT;
        cmd_funct = snn_pkg::F_STORE1;
        cmd_rd    = '0;
        cmd_data  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle(2);                                           // Cleared state seen by checker

        exercise_vector_bank(snn_pkg::UNIT_WEIGHT);
        exercise_vector_bank(snn_pkg::UNIT_SPIKE);

        send(snn_pkg::UNIT_CURRENT, snn_pkg::F_STORE16, 4'd0, rand_vec());
        send(snn_pkg::UNIT_CURRENT, snn_pkg::F_STORE1, 4'd6, rand_vec());
        send(snn_pkg::UNIT_CURRENT, snn_pkg::F_STORE4, 4'd13, rand_vec());
        send(snn_pkg::UNIT_CURRENT, snn_pkg::F_STORE_NIB, 4'd10, rand_vec());
        idle(1);

        send(snn_pkg::UNIT_ACCUM, snn_pkg::F_ACCUM, 4'd0, '0);
        idle(2);
        send(snn_pkg::UNIT_ACCUM, snn_pkg::F_ACCUM, 4'd0, '0);   // Chained through write-back
        send(snn_pkg::UNIT_ACCUM, snn_pkg::F_ACCUM, 4'd0, '0);
        idle(2);

        send(snn_pkg::UNIT_CURRENT, snn_pkg::F_LOAD1, 4'd0, rand_vec());
        idle(1);
        send(snn_pkg::UNIT_WEIGHT, 3'd7, 4'd3, rand_vec());      // Unused code for a bank
        idle(1);
        send(snn_pkg::UNIT_SPIKE, 3'd6, 4'd0, rand_vec());
        idle(1);
        send(snn_pkg::UNIT_ACCUM, snn_pkg::F_STORE1, 4'd0, rand_vec());
        idle(2);

        if (u_dut.u_chk.err_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Checker reported %0d errors", u_dut.u_chk.err_count);
        end
    end

endmodule

`default_nettype wire

/* list.f */
rtl/snn_pkg.sv
rtl/command_decode.sv
rtl/vector_reg_bank.sv
rtl/current_reg_bank.sv
rtl/synapse_accumulator.sv
rtl/snn_core.sv
testbench/snn_core_chk.sv
testbench/snn_core_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the snn_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=snn_core_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module snn_core_tb -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Keep running after an assertion error so the testbench can report it
./obj_dir/"$SIM" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
